// File: common/fifo_async_pkg.sv
/* sizes, word and pointer types, and Gray code helpers for the dual-clock FIFO.
   every RTL file of the FIFO pulls these in with a wildcard import */
package fifo_async_pkg;

    // **************************************************
    // sizes
    // **************************************************

    // width of one stored word
    localparam int DATA_WIDTH = 8;
    // address bits of the storage array
    localparam int PTR_WIDTH = 4;
    // number of words, one per address
    localparam int DEPTH = 1 << PTR_WIDTH;

    // almost-full rises this many words below DEPTH
    localparam int ALMOSTFULL_OFFSET = 2;
    // almost-empty holds while fill is at or below this level
    localparam int ALMOSTEMPTY_OFFSET = 2;

    // **************************************************
    // types
    // **************************************************

    // one stored word
    typedef logic [DATA_WIDTH-1:0] data_t;
    // storage address, pointer without its wrap bit
    typedef logic [PTR_WIDTH-1:0] addr_t;
    // binary or Gray pointer, msb is the wrap bit
    typedef logic [PTR_WIDTH:0] ptr_t;
    // fill level 0..DEPTH, one bit wider than an address
    typedef logic [PTR_WIDTH:0] fill_t;

    // **************************************************
    // Gray code helpers
    // **************************************************

    // binary to reflected Gray, one bit flips per increment
    function automatic ptr_t bin_to_gray(input ptr_t bin);
        return (bin >> 1) ^ bin;
    endfunction

    // Gray back to binary, msb passes through
    function automatic ptr_t gray_to_bin(input ptr_t gray);
        ptr_t bin;
        bin[PTR_WIDTH] = gray[PTR_WIDTH];
        // each lower bit is the xor of all Gray bits above and itself
        for (int i = PTR_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// File: fifo_async.f
+incdir+tb
common/fifo_async_pkg.sv
hdl/dual_clock_ram.sv
hdl/gray_ptr_sync.sv
fifo_ctrl/wr_ptr_full.sv
fifo_ctrl/rd_ptr_empty.sv
hdl/fifo_async.sv
tb/tb_fifo_async.sv

// File: fifo_ctrl/rd_ptr_empty.sv
/* read-domain controller: binary and Gray read pointers, registered empty flag,
   fill level and almost-empty flag, all from the synchronized write pointer */
`timescale 1ns/1ns

module rd_ptr_empty
    import fifo_async_pkg::*;
(
    input  logic  i_rclk,
    input  logic  i_rrstn,
    input  logic  i_rd,
    // write pointer, already in the read domain
    input  ptr_t  i_wgray_sync,

    // head of the FIFO, read combinationally from the storage
    output addr_t o_raddr,

    // Gray pointer for the synchronizer into the write domain
    output ptr_t  o_rgray,

    output logic  o_rempty,
    output logic  o_ralmostempty,
    output fill_t o_rfill
);

    // read pop accepted this cycle
    logic  rd_inc;
    // binary read pointer, wrap bit on top
    ptr_t  rbin;
    ptr_t  rbin_next;
    ptr_t  rgray_next;
    // write pointer decoded back to binary
    ptr_t  wbin_sync;
    fill_t rfill_next;

    // **************************************************
    // read pointer
    // **************************************************

    // a pop while empty is dropped here, nowhere else
    assign rd_inc  = i_rd && !o_rempty;
    // current pointer addresses the head word, fall-through
    assign o_raddr = rbin[PTR_WIDTH-1:0];

    assign rbin_next  = rbin + ptr_t'(rd_inc);
    assign rgray_next = bin_to_gray(rbin_next);

    // **************************************************
    // empty, fill and almost-empty
    // **************************************************

    // empty when both pointers match, wrap bit included
    // the write pointer is two rclk old, so empty releases late
    // but never shows a word that is not yet stored
    assign wbin_sync  = gray_to_bin(i_wgray_sync);
    assign rfill_next = fill_t'(wbin_sync - rbin_next);

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rbin           <= '0;
            o_rgray        <= '0;
            o_rempty       <= 1'b1;
            o_rfill        <= '0;
            o_ralmostempty <= 1'b1;
        end else begin
            rbin           <= rbin_next;
            o_rgray        <= rgray_next;
            o_rempty       <= (rgray_next == i_wgray_sync);
            o_rfill        <= rfill_next;
            // same difference as the fill, so flag and level agree
            o_ralmostempty <= (rfill_next <= fill_t'(ALMOSTEMPTY_OFFSET));
        end
    end

    // **************************************************
    // checks
    // **************************************************

    // the pointer sent across must never move more than one bit
    a_rgray_one_step: assert property (
        @(posedge i_rclk) disable iff (!i_rrstn)
        $countones(o_rgray ^ $past(o_rgray)) <= 1
    ) else $error("read Gray pointer moved more than one bit");

    // an empty FIFO holds its read pointer
    a_no_read_when_empty: assert property (
        @(posedge i_rclk) disable iff (!i_rrstn)
        o_rempty |=> (rbin == $past(rbin))
    ) else $error("read pointer advanced while empty");

    // the write side never runs more than DEPTH ahead of this pointer
    a_rfill_bounded: assert property (
        @(posedge i_rclk) disable iff (!i_rrstn)
        o_rfill <= fill_t'(DEPTH)
    ) else $error("read fill level above DEPTH");

endmodule

// File: fifo_ctrl/wr_ptr_full.sv
/* write-domain controller: binary and Gray write pointers, registered full flag,
   fill level and almost-full flag, all from the synchronized read pointer */
`timescale 1ns/1ns

module wr_ptr_full
    import fifo_async_pkg::*;
(
    input  logic  i_wclk,
    input  logic  i_wrstn,
    input  logic  i_wr,
    // read pointer, already in the write domain
    input  ptr_t  i_rgray_sync,

    // memory write port
    output logic  o_we,
    output addr_t o_waddr,

    // Gray pointer for the synchronizer into the read domain
    output ptr_t  o_wgray,

    output logic  o_wfull,
    output logic  o_walmostfull,
    output fill_t o_wfill
);

    // binary write pointer, wrap bit on top
    ptr_t  wbin;
    ptr_t  wbin_next;
    ptr_t  wgray_next;
    // read pointer decoded back to binary
    ptr_t  rbin_sync;
    fill_t wfill_next;
    logic  wfull_next;

    // **************************************************
    // write pointer
    // **************************************************

    // a write while full is dropped here, nowhere else
    assign o_we    = i_wr && !o_wfull;
    assign o_waddr = wbin[PTR_WIDTH-1:0];

    assign wbin_next  = wbin + ptr_t'(o_we);
    assign wgray_next = bin_to_gray(wbin_next);

    // **************************************************
    // full, fill and almost-full
    // **************************************************

    // full when the write pointer is one lap ahead
    // in Gray terms the top two bits differ, the rest match
    assign wfull_next = (wgray_next == {~i_rgray_sync[PTR_WIDTH:PTR_WIDTH-1],
                                         i_rgray_sync[PTR_WIDTH-2:0]});

    // modular difference, the wrap bit lets it reach DEPTH
    assign rbin_sync  = gray_to_bin(i_rgray_sync);
    assign wfill_next = fill_t'(wbin_next - rbin_sync);

    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wbin          <= '0;
            o_wgray       <= '0;
            o_wfull       <= 1'b0;
            o_wfill       <= '0;
            o_walmostfull <= 1'b0;
        end else begin
            wbin          <= wbin_next;
            o_wgray       <= wgray_next;
            // flags come from the next pointer, so they match it on this edge
            o_wfull       <= wfull_next;
            o_wfill       <= wfill_next;
            o_walmostfull <= (wfill_next >= fill_t'(DEPTH - ALMOSTFULL_OFFSET));
        end
    end

    // **************************************************
    // checks
    // **************************************************

    // the pointer sent across must never move more than one bit
    a_wgray_one_step: assert property (
        @(posedge i_wclk) disable iff (!i_wrstn)
        $countones(o_wgray ^ $past(o_wgray)) <= 1
    ) else $error("write Gray pointer moved more than one bit");

    // a full FIFO holds its write pointer
    a_no_write_when_full: assert property (
        @(posedge i_wclk) disable iff (!i_wrstn)
        o_wfull |=> (wbin == $past(wbin))
    ) else $error("write pointer advanced while full");

endmodule

// File: hdl/dual_clock_ram.sv
/* FIFO storage, DEPTH words written on i_wclk and read without a clock.
   fits distributed RAM so the head word can fall through to the read port */
`timescale 1ns/1ns

module dual_clock_ram
    import fifo_async_pkg::*;
(
    // write port, i_wclk domain
    input  logic  i_wclk,
    input  logic  i_we,
    input  addr_t i_waddr,
    input  data_t i_wdata,

    // read port, combinational
    input  addr_t i_raddr,
    output data_t o_rdata
);

    // **************************************************
    // storage array
    // **************************************************

    // contents are defined only by writes
    data_t mem [DEPTH];

    // write on the edge that accepts the word
    // i_we already excludes writes while full
    always_ff @(posedge i_wclk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // **************************************************
    // read port
    // **************************************************

    // zero-latency read, the addressed word is always visible
    // the read address belongs to i_rclk, but a slot is never
    // written while it is the head of a non-empty FIFO
    assign o_rdata = mem[i_raddr];

endmodule

// File: hdl/fifo_async.sv
/* dual-clock FIFO top level, first-word fall-through on the read side.
   wires the storage, both pointer controllers and the two pointer synchronizers */
`timescale 1ns/1ns

module fifo_async
    import fifo_async_pkg::*;
(
    // write side, i_wclk domain
    input  logic  i_wclk,
    input  logic  i_wrstn,
    input  logic  i_wr,
    input  data_t i_wdata,
    output logic  o_wfull,
    output logic  o_walmostfull,
    output fill_t o_wfill,

    // read side, i_rclk domain
    input  logic  i_rclk,
    input  logic  i_rrstn,
    input  logic  i_rd,
    output data_t o_rdata,
    output logic  o_rempty,
    output logic  o_ralmostempty,
    output fill_t o_rfill
);

    // memory write port, write domain
    logic  we;
    addr_t waddr;
    // memory read address, read domain
    addr_t raddr;

    // Gray pointers in their own domain
    logic [PTR_WIDTH:0] wgray;
    logic [PTR_WIDTH:0] rgray;
    // Gray pointers after crossing
    ptr_t  wgray_sync;
    ptr_t  rgray_sync;

    // **************************************************
    // storage
    // **************************************************

    dual_clock_ram ram_i (
        .i_wclk  (i_wclk),
        .i_we    (we),
        .i_waddr (waddr),
        .i_wdata (i_wdata),
        .i_raddr (raddr),
        .o_rdata (o_rdata)
    );

    // **************************************************
    // write domain
    // **************************************************

    wr_ptr_full wr_ctrl_i (
        .i_wclk        (i_wclk),
        .i_wrstn       (i_wrstn),
        .i_wr          (i_wr),
        .i_rgray_sync  (rgray_sync),
        .o_we          (we),
        .o_waddr       (waddr),
        .o_wgray       (wgray),
        .o_wfull       (o_wfull),
        .o_walmostfull (o_walmostfull),
        .o_wfill       (o_wfill)
    );

    // read pointer into the write domain, feeds full and write fill
    gray_ptr_sync r2w_sync_i (
        .i_clk  (i_wclk),
        .i_rstn (i_wrstn),
        .i_gray (rgray),
        .o_gray (rgray_sync)
    );

    // **************************************************
    // read domain
    // **************************************************

    // write pointer into the read domain, feeds empty and read fill
    gray_ptr_sync w2r_sync_i (
        .i_clk  (i_rclk),
        .i_rstn (i_rrstn),
        .i_gray (wgray),
        .o_gray (wgray_sync)
    );

    rd_ptr_empty rd_ctrl_i (
        .i_rclk         (i_rclk),
        .i_rrstn        (i_rrstn),
        .i_rd           (i_rd),
        .i_wgray_sync   (wgray_sync),
        .o_raddr        (raddr),
        .o_rgray        (rgray),
        .o_rempty       (o_rempty),
        .o_ralmostempty (o_ralmostempty),
        .o_rfill        (o_rfill)
    );

endmodule

// File: hdl/gray_ptr_sync.sv
/* two-flop synchronizer that brings a Gray pointer into another clock domain.
   clock and reset belong to the destination side */
`timescale 1ns/1ns

module gray_ptr_sync
    import fifo_async_pkg::*;
(
    input  logic i_clk,
    input  logic i_rstn,
    input  ptr_t i_gray,
    output ptr_t o_gray
);

    // first stage, may go metastable
    ptr_t gray_meta;

    // only Gray values may cross here
    // one bit moves per pointer step, so a flop caught mid-change
    // still settles to either the old or the new pointer
    // a binary count could land on an unrelated value
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            gray_meta <= '0;
            o_gray    <= '0;
        end else begin
            gray_meta <= i_gray;
            // second stage gives the first a full cycle to resolve
            o_gray    <= gray_meta;
        end
    end

endmodule

// File: tb/tb_fifo_tasks.svh
/* push, pop and wait tasks for the dual-clock FIFO testbench.
   included inside the testbench module, so DUT signals and the model are in scope */
`ifndef TB_FIFO_TASKS_SVH
`define TB_FIFO_TASKS_SVH

// back-to-back writes of random words where the DUT drops any taken while full
task automatic write_burst(input int n);
    for (int i = 0; i < n; i++) begin
        @(negedge i_wclk);
        i_wr    = 1'b1;
        i_wdata = data_t'($urandom);
    end
    @(negedge i_wclk);
    i_wr = 1'b0;
endtask

task automatic wait_wfull();
    int cycles;
    cycles = 0;
    while (!o_wfull && cycles < WAIT_LIMIT) begin
        @(negedge i_wclk);
        cycles++;
    end
    if (!o_wfull) begin
        report_failure("timeout waiting for o_wfull to rise after filling the FIFO");
    end
endtask

task automatic wait_rempty();
    int cycles;
    cycles = 0;
    while (!o_rempty && cycles < WAIT_LIMIT) begin
        @(negedge i_rclk);
        cycles++;
    end
    if (!o_rempty) begin
        report_failure("timeout waiting for o_rempty to return high");
    end
endtask

// one pop once o_rempty has gone low
task automatic pop_word();
    int cycles;
    cycles = 0;
    @(negedge i_rclk);
    while (o_rempty && cycles < WAIT_LIMIT) begin
        @(negedge i_rclk);
        cycles++;
    end
    if (o_rempty) begin
        report_failure("timeout waiting for a word to read, o_rempty stayed high");
    end else begin
        i_rd = 1'b1;
        @(negedge i_rclk);
        i_rd = 1'b0;
    end
endtask

// i_rd held high on an empty FIFO where these pops must be ignored
task automatic probe_empty_reads(input int n);
    for (int i = 0; i < n; i++) begin
        @(negedge i_rclk);
        i_rd = 1'b1;
    end
    @(negedge i_rclk);
    i_rd = 1'b0;
endtask

// writes on about half the wclk cycles and reads on about three quarters of rclk cycles
task automatic random_traffic(input int wr_cycles, input int rd_cycles);
    fork
        begin
            for (int i = 0; i < wr_cycles; i++) begin
                @(negedge i_wclk);
                i_wr    = ($urandom % 2) != 0;
                i_wdata = data_t'($urandom);
            end
            @(negedge i_wclk);
            i_wr = 1'b0;
        end
        begin
            for (int i = 0; i < rd_cycles; i++) begin
                @(negedge i_rclk);
                i_rd = ($urandom % 4) != 0;
            end
            @(negedge i_rclk);
            i_rd = 1'b0;
        end
    join
endtask

// pop until the model is empty with each pop bounded by its own timeout
task automatic drain_fifo();
    while (model_count > 0) begin
        pop_word();
    end
    wait_rempty();
endtask

`endif

// File: tb/tb_fifo_async.sv
/* testbench for the dual-clock FIFO with two free-running clocks, a reference model of the
   contents, the checking assertions and the directed and random traffic phases */
`timescale 1ns/1ns

module tb_fifo_async
    import fifo_async_pkg::*;
();

    // cycles any single wait may take before it counts as a hang
    localparam int WAIT_LIMIT = 200;
    // reference model depth far above what the FIFO can hold
    localparam int MODEL_SIZE = 64;

    logic  i_wclk;
    logic  i_wrstn;
    logic  i_wr;
    data_t i_wdata;
    logic  o_wfull;
    logic  o_walmostfull;
    fill_t o_wfill;
    logic  i_rclk;
    logic  i_rrstn;
    logic  i_rd;
    data_t o_rdata;
    logic  o_rempty;
    logic  o_ralmostempty;
    fill_t o_rfill;

    // reference model as a ring with one counter per domain
    data_t sent_words [MODEL_SIZE];
    int    wr_count;
    int    rd_count;
    int    model_count;
    data_t expected_head;

    fifo_async dut_i (.*);

    // **************************************************
    // failure reporting
    // **************************************************

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        report_failure($sformatf("mismatch in %s: expected 0x%0h, actual 0x%0h",
                                 test_name, expected, actual));
    endtask

    `include "tb_fifo_tasks.svh"

    // **************************************************
    // clocks and reference model
    // **************************************************

    initial begin
        i_wclk = 1'b0;
        forever #10 i_wclk = ~i_wclk;
    end

    // odd offset keeps rclk rising edges away from wclk rising edges
    initial begin
        i_rclk = 1'b0;
        #4;
        forever #17 i_rclk = ~i_rclk;
    end

    // an accepted write appends as judged by the flag before the edge
    always @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wr_count <= 0;
        end else if (i_wr && !o_wfull) begin
            sent_words[wr_count % MODEL_SIZE] <= i_wdata;
            wr_count <= wr_count + 1;
        end
    end

    // an accepted read drops the head
    always @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rd_count <= 0;
        end else if (i_rd && !o_rempty) begin
            rd_count <= rd_count + 1;
        end
    end

    assign model_count   = wr_count - rd_count;
    assign expected_head = sent_words[rd_count % MODEL_SIZE];

    // **************************************************
    // checks
    // **************************************************

    // reset values as seen on the first edge after release
    reset_write_values: assert property (@(posedge i_wclk)
        $rose(i_wrstn) |-> ({o_wfull, o_walmostfull, o_wfill} == 7'h00)
    ) else report_mismatch("reset_write_values", 32'h00,
                           $sampled({o_wfull, o_walmostfull, o_wfill}));

    reset_read_values: assert property (@(posedge i_rclk)
        $rose(i_rrstn) |-> ({o_rempty, o_ralmostempty, o_rfill} == 7'h60)
    ) else report_mismatch("reset_read_values", 32'h60,
                           $sampled({o_rempty, o_ralmostempty, o_rfill}));

    // fall-through head must match the oldest model word on every pop
    read_order: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        (i_rd && !o_rempty) |-> (o_rdata == expected_head)
    ) else report_mismatch("read_order", $sampled(expected_head), $sampled(o_rdata));

    // pessimistic flags never show a word or a fill level that was not written
    nonempty_has_data: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        !o_rempty |-> (model_count > 0)
    ) else report_failure("o_rempty is low while the model holds no word");

    rfill_not_ahead: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        o_rfill <= model_count
    ) else report_failure("o_rfill counts more words than were written");

    // empty sits exactly at fill zero just as full sits at DEPTH
    empty_matches_fill: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        o_rempty == (o_rfill == fill_t'(0))
    ) else report_mismatch("empty_matches_fill", $sampled(o_rfill == fill_t'(0)),
                           $sampled(o_rempty));

    // full sits exactly at fill DEPTH, and dropped writes never grow the model
    full_matches_fill: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        o_wfull == (o_wfill == fill_t'(DEPTH))
    ) else report_mismatch("full_matches_fill", $sampled(o_wfill == fill_t'(DEPTH)),
                           $sampled(o_wfull));

    model_bounded: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        model_count <= DEPTH
    ) else report_failure("a write was accepted while the FIFO already held DEPTH words");

    walmostfull_rule: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        o_walmostfull == (o_wfill >= fill_t'(DEPTH - ALMOSTFULL_OFFSET))
    ) else report_mismatch("walmostfull_rule",
                           $sampled(o_wfill >= fill_t'(DEPTH - ALMOSTFULL_OFFSET)),
                           $sampled(o_walmostfull));

    wfill_bounded: assert property (@(posedge i_wclk) disable iff (!i_wrstn)
        o_wfill <= fill_t'(DEPTH)
    ) else report_failure("o_wfill went above DEPTH");

    ralmostempty_rule: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        o_ralmostempty == (o_rfill <= fill_t'(ALMOSTEMPTY_OFFSET))
    ) else report_mismatch("ralmostempty_rule",
                           $sampled(o_rfill <= fill_t'(ALMOSTEMPTY_OFFSET)),
                           $sampled(o_ralmostempty));

    rfill_bounded: assert property (@(posedge i_rclk) disable iff (!i_rrstn)
        o_rfill <= fill_t'(DEPTH)
    ) else report_failure("o_rfill went above DEPTH");

    // **************************************************
    // test sequence
    // **************************************************

    initial begin
        void'($urandom(32'ha52c));
        i_wrstn = 1'b0;
        i_rrstn = 1'b0;
        i_wr    = 1'b0;
        i_wdata = '0;
        i_rd    = 1'b0;

        // each reset released after 3 cycles of its own clock
        fork
            begin
                repeat (3) @(posedge i_wclk);
                @(negedge i_wclk);
                i_wrstn = 1'b1;
            end
            begin
                repeat (3) @(posedge i_rclk);
                @(negedge i_rclk);
                i_rrstn = 1'b1;
            end
        join
        repeat (2) @(negedge i_rclk);

        // fill past DEPTH, then read back the words that were kept
        write_burst(DEPTH + 4);
        wait_wfull();
        repeat (DEPTH) pop_word();
        wait_rempty();

        // pops on an empty FIFO, then one word straight through
        probe_empty_reads(4);
        write_burst(1);
        pop_word();
        wait_rempty();

        // concurrent random traffic, then drain
        random_traffic(400, 240);
        drain_fifo();

        $display("Test passed");
        $finish;
    end

endmodule
